/* Bender.yml */
package:
  name: nand_program_engine

sources:
  - logic/nandProgramPkg.sv
  - logic/commandIngress.sv
  - logic/writeDataBuffer.sv
  - logic/pageProgramSequencer.sv
  - logic/primitiveExecutor.sv
  - logic/nandProgramEngine.sv
  - target: test
    files:
      - bench/nandProgramEngineTb.sv

/* bench/nandProgramEngineTb.sv */
module nandProgramEngineTb
    import nandProgramPkg::*;
();
    localparam int ClockHalf = 20;
    localparam int DriveDelay = 2;

    logic                    iSystemClock;
    logic                    rst;
    logic                    cmdValid;
    logic [5:0]              cmdOpcode;
    logic [NumberOfWays-1:0] cmdWaySelect;
    logic [15:0]             cmdColAddress;
    logic [23:0]             cmdRowAddress;
    logic [15:0]             cmdLength;
    logic                    cmdCreditReturn;
    logic                    cmdRejected;
    logic                    dataValid;
    logic [31:0]             data;
    logic                    dataLast;
    logic                    dataCreditReturn;
    logic                    programDone;
    logic [NumberOfWays-1:0] nandCe;
    logic                    nandCle;
    logic                    nandAle;
    logic                    nandWe;
    logic [7:0]              nandDq;

    // command table with one entry per host command.
    int tblOpcode[$];
    int tblWay[$];
    int tblLength[$];
    int tblAccepted[$];
    int tblWaitIdle[$];
    int tblDelay[$];

    logic [13:0] expectQ[$]; // {ce, cle, ale, dq}.
    int          cumQ[$]; // bytes on the bus when each programDone is due.
    logic [31:0] wordQ[$];
    logic        lastQ[$];
    int          delayQ[$];

    int cmdCredits = CmdQueueDepth;
    int dataCredits = DataBufferDepth;
    int cmdReturnCount = 0;
    int rejectCount = 0;
    int dataReturnCount = 0;
    int bytesSeen = 0;
    int doneCount = 0;
    int acceptedSent = 0;
    int commandsSent = 0;
    int wordsSent = 0;
    int totalWords = 0;
    int expectedRejects = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    int unsigned seedValue;
    int unsigned randomScratch;

    nandProgramEngine nandProgramEngine_i (.*);

    initial
    begin
        iSystemClock = 1'b0;
        forever #ClockHalf iSystemClock = ~iSystemClock;
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string message);
        if (actual !== expected)
        begin
            $display("FAILED at time %0t: %s (got %0h, expected %0h)", $time, message,
                     actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic addCommand(input int opcode, input int way, input int length,
                              input int accepted, input int waitIdle, input int delay);
        tblOpcode.push_back(opcode);
        tblWay.push_back(way);
        tblLength.push_back(length);
        tblAccepted.push_back(accepted);
        tblWaitIdle.push_back(waitIdle);
        tblDelay.push_back(delay);
        cycleLimit += 6 + 4 * length + TadlCycles + ProgramCycles + 40;
        if (accepted != 0)
            totalWords += length;
        else
            expectedRejects++;
    endtask

    task automatic stepCycle;
        @(posedge iSystemClock);
        #DriveDelay;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host command and data ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic sendCommands;
        logic [15:0]             col;
        logic [23:0]             row;
        logic [31:0]             word;
        logic [NumberOfWays-1:0] ce;
        for (int i = 0; i < tblOpcode.size(); i++)
        begin
            if (tblWaitIdle[i] != 0)
                while (doneCount != acceptedSent) stepCycle();
            while (cmdCredits == 0) stepCycle();
            col = 16'($urandom);
            row = 24'($urandom);
            ce = NumberOfWays'(1 << tblWay[i]);
            cmdValid = 1'b1;
            cmdOpcode = 6'(tblOpcode[i]);
            cmdWaySelect = ce;
            cmdColAddress = col;
            cmdRowAddress = row;
            cmdLength = 16'(tblLength[i]);
            cmdCredits--;
            commandsSent++;
            if (tblAccepted[i] != 0)
            begin
                expectQ.push_back({ce, 2'b10, CmdProgramSetup});
                expectQ.push_back({ce, 2'b01, col[7:0]});
                expectQ.push_back({ce, 2'b01, col[15:8]});
                expectQ.push_back({ce, 2'b01, row[7:0]});
                expectQ.push_back({ce, 2'b01, row[15:8]});
                expectQ.push_back({ce, 2'b01, row[23:16]});
                for (int w = 0; w < tblLength[i]; w++)
                begin
                    word = $urandom;
                    wordQ.push_back(word);
                    lastQ.push_back(w == tblLength[i] - 1);
                    delayQ.push_back((w == 0) ? tblDelay[i] : 0);
                    for (int b = 0; b < 4; b++)
                        expectQ.push_back({ce, 2'b00, word[8*b +: 8]}); // lsb first.
                end
                expectQ.push_back({ce, 2'b10, CmdProgramConfirm});
                acceptedSent++;
                cumQ.push_back(expectQ.size() + bytesSeen);
            end
            stepCycle();
            cmdValid = 1'b0;
        end
    endtask

    task automatic feedData;
        while (wordsSent < totalWords)
        begin
            dataValid = 1'b0;
            if ((wordQ.size() == 0) || (dataCredits == 0))
                stepCycle();
            else
            begin
                repeat (delayQ.pop_front()) stepCycle(); // late data for the stall case.
                dataValid = 1'b1;
                data = wordQ.pop_front();
                dataLast = lastQ.pop_front();
                dataCredits--;
                wordsSent++;
                stepCycle();
            end
        end
        dataValid = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus monitor and credit accounting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge iSystemClock)
    begin
        if (!rst)
        begin
            if (cmdCreditReturn)
            begin
                cmdCredits++;
                cmdReturnCount++;
            end
            if (cmdRejected)
                rejectCount++;
            if (dataCreditReturn)
            begin
                dataCredits++;
                dataReturnCount++;
            end
            if (nandWe)
            begin
                checkValue(expectQ.size() != 0, 1, "bus strobe with no byte expected");
                checkValue({nandCe, nandCle, nandAle, nandDq}, expectQ.pop_front(),
                           "bus byte, chip enable or latch flags wrong");
                bytesSeen++;
            end
            if (programDone)
            begin
                checkValue(cumQ.size() != 0, 1, "programDone with no command pending");
                checkValue(bytesSeen, cumQ.pop_front(), "programDone before its bytes ended");
                doneCount++;
            end
        end
    end

    always @(posedge iSystemClock)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: the engine did not finish all commands in %0d cycles", cycleLimit);
            $display("Some tests failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    initial
    begin
        seedValue = 32'h310278f0;
        randomScratch = $urandom(seedValue);
        // opcode, way, length, accepted, wait for idle, data delay.
        addCommand(OpProgram, 0, 2, 1, 0, 0);
        addCommand(OpProgram, 1, 1, 1, 1, 0);
        addCommand(OpProgram, 2, 3, 1, 1, 0);
        addCommand(OpProgram, 3, 1, 1, 1, 0);
        addCommand(6'b000001, 0, 4, 0, 1, 0); // rejected as not a program.
        addCommand(OpProgram, 0, 2, 1, 0, 0);
        addCommand(OpProgram, 1, 2, 1, 1, 0); // pair sent with full credits.
        addCommand(OpProgram, 2, 3, 1, 0, 0);
        addCommand(OpProgram, 3, 4, 1, 1, 60); // data well after tADL.

        rst = 1'b1;
        cmdValid = 1'b0;
        cmdOpcode = '0;
        cmdWaySelect = '0;
        cmdColAddress = '0;
        cmdRowAddress = '0;
        cmdLength = '0;
        dataValid = 1'b0;
        data = '0;
        dataLast = 1'b0;
        repeat (5) stepCycle();
        rst = 1'b0;

        repeat (4)
        begin
            @(negedge iSystemClock);
            checkValue({nandWe, nandCle, nandAle, nandCe, cmdCreditReturn, cmdRejected,
                        dataCreditReturn, programDone}, 0, "output active after reset");
        end
        stepCycle();

        fork
            sendCommands();
            feedData();
        join
        while (doneCount != acceptedSent) stepCycle();
        repeat (4) stepCycle();

        checkValue(rejectCount, expectedRejects, "cmdRejected pulse count");
        checkValue(cmdReturnCount, commandsSent, "cmdCreditReturn pulse count");
        checkValue(dataReturnCount, wordsSent, "dataCreditReturn pulse count");
        $display("All tests passed");
        $finish;
    end

endmodule

/* files.f */
logic/nandProgramPkg.sv
logic/commandIngress.sv
logic/writeDataBuffer.sv
logic/pageProgramSequencer.sv
logic/primitiveExecutor.sv
logic/nandProgramEngine.sv
bench/nandProgramEngineTb.sv

/* logic/commandIngress.sv */
module commandIngress
    import nandProgramPkg::*;
(
    input  logic                    iSystemClock,
    input  logic                    rst,
    input  logic                    cmdValid,
    input  logic [5:0]              cmdOpcode,
    input  logic [NumberOfWays-1:0] cmdWaySelect,
    input  logic [15:0]             cmdColAddress,
    input  logic [23:0]             cmdRowAddress,
    input  logic [15:0]             cmdLength,
    input  logic                    queuePop,
    output logic                    cmdCreditReturn,
    output logic                    cmdRejected,
    output logic                    queueNotEmpty,
    output logic [NumberOfWays-1:0] headWaySelect,
    output logic [15:0]             headColAddress,
    output logic [23:0]             headRowAddress,
    output logic [15:0]             headLength
);
    logic [NumberOfWays-1:0]          wayStore [CmdQueueDepth];
    logic [15:0]                      colStore [CmdQueueDepth];
    logic [23:0]                      rowStore [CmdQueueDepth];
    logic [15:0]                      lengthStore [CmdQueueDepth];
    logic [$clog2(CmdQueueDepth)-1:0] writePtr;
    logic [$clog2(CmdQueueDepth)-1:0] readPtr;
    logic [$clog2(CmdQueueDepth):0]   entryCount;
    logic [1:0]                       creditOwed;
    logic [1:0]                       creditDue;
    logic                             accept;
    logic                             reject;

    assign accept = cmdValid && (cmdOpcode == OpProgram);
    assign reject = cmdValid && (cmdOpcode != OpProgram);
    assign creditDue = creditOwed + {1'b0, queuePop} + {1'b0, reject}; // pop and reject may collide.

    assign queueNotEmpty = (entryCount != '0);
    assign headWaySelect = wayStore[readPtr];
    assign headColAddress = colStore[readPtr];
    assign headRowAddress = rowStore[readPtr];
    assign headLength = lengthStore[readPtr];

    always_ff @(posedge iSystemClock)
    begin
        if (accept)
        begin
            wayStore[writePtr] <= cmdWaySelect;
            colStore[writePtr] <= cmdColAddress;
            rowStore[writePtr] <= cmdRowAddress;
            lengthStore[writePtr] <= cmdLength;
        end
    end

    always_ff @(posedge iSystemClock)
    begin
        if (rst)
        begin
            writePtr <= '0;
            readPtr <= '0;
            entryCount <= '0;
            creditOwed <= 2'd0;
            cmdCreditReturn <= 1'b0;
            cmdRejected <= 1'b0;
        end
        else
        begin
            if (accept)
                writePtr <= writePtr + 1'b1;
            if (queuePop)
                readPtr <= readPtr + 1'b1;
            if (accept && !queuePop)
                entryCount <= entryCount + 1'b1;
            else if (!accept && queuePop)
                entryCount <= entryCount - 1'b1;
            cmdRejected <= reject;
            cmdCreditReturn <= (creditDue != 2'd0); // one credit per cycle.
            creditOwed <= (creditDue != 2'd0) ? creditDue - 2'd1 : 2'd0;
        end
    end

endmodule

/* logic/nandProgramEngine.sv */
module nandProgramEngine
    import nandProgramPkg::*;
(
    input  logic                    iSystemClock,
    input  logic                    rst,
    input  logic                    cmdValid,
    input  logic [5:0]              cmdOpcode,
    input  logic [NumberOfWays-1:0] cmdWaySelect,
    input  logic [15:0]             cmdColAddress,
    input  logic [23:0]             cmdRowAddress,
    input  logic [15:0]             cmdLength,
    output logic                    cmdCreditReturn,
    output logic                    cmdRejected,
    input  logic                    dataValid,
    input  logic [31:0]             data,
    input  logic                    dataLast,
    output logic                    dataCreditReturn,
    output logic                    programDone,
    output logic [NumberOfWays-1:0] nandCe,
    output logic                    nandCle,
    output logic                    nandAle,
    output logic                    nandWe,
    output logic [7:0]              nandDq
);
    // ingress to sequencer.
    logic                    queuePop;
    logic                    queueNotEmpty;
    logic [NumberOfWays-1:0] headWaySelect;
    logic [15:0]             headColAddress;
    logic [23:0]             headRowAddress;
    logic [15:0]             headLength;

    // sequencer to executor.
    logic                    primReady;
    logic [2:0]              primLastStep;
    logic [2:0]              primCommand;
    logic                    primOption;
    logic [NumberOfWays-1:0] primTargetWay;
    logic [15:0]             primCount;
    logic                    caSelect;
    logic [7:0]              caData;

    // buffer to executor.
    logic                    bufferPop;
    logic                    bufferNotEmpty;
    logic [31:0]             bufferData;
    logic                    bufferLast;

    commandIngress commandIngress_i (.*);

    writeDataBuffer writeDataBuffer_i (.*);

    pageProgramSequencer pageProgramSequencer_i (.*);

    primitiveExecutor primitiveExecutor_i (.*);

endmodule

/* logic/nandProgramPkg.sv */
package nandProgramPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NumberOfWays = 4;
    localparam logic [5:0] OpProgram = 6'b000100; // page program.
    localparam int CmdQueueDepth = 2;
    localparam int DataBufferDepth = 8; // 32-bit words.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flash side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [7:0] CmdProgramSetup = 8'h80;
    localparam logic [7:0] CmdProgramConfirm = 8'h10;

    localparam logic [2:0] PrimCaLatch = 3'b001; // command/address latch.
    localparam logic [2:0] PrimDataOut = 3'b010; // data-out burst.
    localparam logic [2:0] PrimTimer = 3'b100; // idle wait.

    localparam logic OptTimerTadl = 1'b0;
    localparam logic OptTimerProgram = 1'b1;
    localparam int TadlCycles = 31;
    localparam int ProgramCycles = 3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [3:0] StateIdle = 4'd0;
    localparam logic [3:0] StateCaIssue0 = 4'd1;
    localparam logic [3:0] StateCmdWrite0 = 4'd2;
    localparam logic [3:0] StateAddrWrite0 = 4'd3;
    localparam logic [3:0] StateAddrWrite1 = 4'd4;
    localparam logic [3:0] StateAddrWrite2 = 4'd5;
    localparam logic [3:0] StateAddrWrite3 = 4'd6;
    localparam logic [3:0] StateAddrWrite4 = 4'd7;
    localparam logic [3:0] StateTadlIssue = 4'd8;
    localparam logic [3:0] StateDataIssue = 4'd9;
    localparam logic [3:0] StateCaIssue1 = 4'd10;
    localparam logic [3:0] StateCmdWrite1 = 4'd11;
    localparam logic [3:0] StateTimerIssue = 4'd12;
    localparam logic [3:0] StateWaitDone = 4'd13;

endpackage

/* logic/pageProgramSequencer.sv */
module pageProgramSequencer
    import nandProgramPkg::*;
(
    input  logic                    iSystemClock,
    input  logic                    rst,
    input  logic                    queueNotEmpty,
    input  logic [NumberOfWays-1:0] headWaySelect,
    input  logic [15:0]             headColAddress,
    input  logic [23:0]             headRowAddress,
    input  logic [15:0]             headLength,
    input  logic                    primReady,
    input  logic [2:0]              primLastStep,
    output logic                    queuePop,
    output logic [2:0]              primCommand,
    output logic                    primOption,
    output logic [NumberOfWays-1:0] primTargetWay,
    output logic [15:0]             primCount,
    output logic                    caSelect,
    output logic [7:0]              caData,
    output logic                    programDone
);
    logic [3:0]              currentState;
    logic [3:0]              nextState;
    logic [NumberOfWays-1:0] targetWay;
    logic [15:0]             colAddress;
    logic [23:0]             rowAddress;
    logic [15:0]             wordLength;
    logic                    latchDone;
    logic                    dataDone;
    logic                    timerDone;

    assign latchDone = |(primLastStep & PrimCaLatch);
    assign dataDone = |(primLastStep & PrimDataOut);
    assign timerDone = |(primLastStep & PrimTimer);

    assign queuePop = (currentState == StateIdle) && queueNotEmpty;
    assign primTargetWay = targetWay;
    assign caSelect = (currentState >= StateAddrWrite0) && (currentState <= StateAddrWrite4);

    always_ff @(posedge iSystemClock)
    begin
        if (rst)
        begin
            currentState <= StateIdle;
            programDone <= 1'b0;
        end
        else
        begin
            currentState <= nextState;
            programDone <= (currentState == StateWaitDone) && timerDone;
        end
    end

    always_ff @(posedge iSystemClock)
    begin
        if (queuePop)
        begin
            targetWay <= headWaySelect;
            colAddress <= headColAddress;
            rowAddress <= headRowAddress;
            wordLength <= headLength;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        nextState = currentState;
        case (currentState)
            StateIdle:       if (queueNotEmpty) nextState = StateCaIssue0;
            StateCaIssue0:   if (primReady) nextState = StateCmdWrite0;
            StateCmdWrite0:  nextState = StateAddrWrite0;
            StateAddrWrite0: nextState = StateAddrWrite1;
            StateAddrWrite1: nextState = StateAddrWrite2;
            StateAddrWrite2: nextState = StateAddrWrite3;
            StateAddrWrite3: nextState = StateAddrWrite4;
            StateAddrWrite4: if (latchDone) nextState = StateTadlIssue;
            StateTadlIssue:
            begin
                if (timerDone)
                    nextState = (wordLength == 16'd0) ? StateCaIssue1 : StateDataIssue;
            end
            StateDataIssue:  if (dataDone) nextState = StateCaIssue1;
            StateCaIssue1:   if (primReady) nextState = StateCmdWrite1;
            StateCmdWrite1:  if (latchDone) nextState = StateTimerIssue;
            StateTimerIssue: if (primReady) nextState = StateWaitDone;
            StateWaitDone:   if (timerDone) nextState = StateIdle;
            default:         nextState = StateIdle;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // primitive request and latch bytes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        primCommand = 3'b000;
        primOption = OptTimerTadl;
        primCount = 16'd0;
        case (currentState)
            StateCaIssue0:
            begin
                primCommand = PrimCaLatch;
                primCount = 16'd6; // setup byte plus five address bytes.
            end
            StateTadlIssue:
            begin
                primCommand = PrimTimer;
                primOption = OptTimerTadl;
            end
            StateDataIssue:
            begin
                primCommand = PrimDataOut;
                primCount = wordLength;
            end
            StateCaIssue1:
            begin
                primCommand = PrimCaLatch;
                primCount = 16'd1;
            end
            StateTimerIssue:
            begin
                primCommand = PrimTimer;
                primOption = OptTimerProgram;
            end
            default:
            begin
                primCommand = 3'b000;
            end
        endcase
    end

    always_comb
    begin
        case (currentState)
            StateCmdWrite0:  caData = CmdProgramSetup;
            StateAddrWrite0: caData = colAddress[7:0];
            StateAddrWrite1: caData = colAddress[15:8];
            StateAddrWrite2: caData = rowAddress[7:0];
            StateAddrWrite3: caData = rowAddress[15:8];
            StateAddrWrite4: caData = rowAddress[23:16];
            StateCmdWrite1:  caData = CmdProgramConfirm;
            default:         caData = 8'h00;
        endcase
    end

endmodule

/* logic/primitiveExecutor.sv */
module primitiveExecutor
    import nandProgramPkg::*;
(
    input  logic                    iSystemClock,
    input  logic                    rst,
    input  logic [2:0]              primCommand,
    input  logic                    primOption,
    input  logic [NumberOfWays-1:0] primTargetWay,
    input  logic [15:0]             primCount,
    input  logic                    caSelect,
    input  logic [7:0]              caData,
    input  logic                    bufferNotEmpty,
    input  logic [31:0]             bufferData,
    input  logic                    bufferLast,
    output logic                    primReady,
    output logic [2:0]              primLastStep,
    output logic                    bufferPop,
    output logic [NumberOfWays-1:0] nandCe,
    output logic                    nandCle,
    output logic                    nandAle,
    output logic                    nandWe,
    output logic [7:0]              nandDq
);
    logic [2:0]  execState; // code of the running primitive, zero when idle.
    logic [15:0] stepCounter;
    logic [1:0]  byteLane;
    logic        timerOption;
    logic        stepFinish;
    logic        latchActive;
    logic        dataActive;

    assign primReady = (execState == 3'b000);
    assign latchActive = (execState == PrimCaLatch);
    assign dataActive = (execState == PrimDataOut) && bufferNotEmpty;
    assign bufferPop = dataActive && (byteLane == 2'd3);
    assign primLastStep = stepFinish ? execState : 3'b000;

    always_comb
    begin
        case (execState)
            PrimCaLatch: stepFinish = (stepCounter == 16'd0);
            PrimDataOut: stepFinish = bufferPop && ((stepCounter == 16'd0) || bufferLast);
            PrimTimer:   stepFinish = (stepCounter == 16'd0);
            default:     stepFinish = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // primitive control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge iSystemClock)
    begin
        if (rst)
        begin
            execState <= 3'b000;
            stepCounter <= 16'd0;
            byteLane <= 2'd0;
            nandCe <= '0;
        end
        else if (primReady)
        begin
            if (primCommand != 3'b000)
            begin
                execState <= primCommand;
                byteLane <= 2'd0;
                if (primCommand == PrimTimer)
                    stepCounter <= (primOption == OptTimerTadl) ? 16'(TadlCycles - 1)
                                                                 : 16'(ProgramCycles - 1);
                else
                    stepCounter <= primCount - 16'd1;
                if (primCommand == PrimCaLatch)
                    nandCe <= primTargetWay; // held through the program wait.
            end
        end
        else if (stepFinish)
        begin
            execState <= 3'b000;
            byteLane <= 2'd0;
            if ((execState == PrimTimer) && (timerOption == OptTimerProgram))
                nandCe <= '0;
        end
        else if (execState != PrimDataOut)
            stepCounter <= stepCounter - 16'd1;
        else if (bufferNotEmpty)
        begin
            byteLane <= byteLane + 2'd1;
            if (byteLane == 2'd3)
                stepCounter <= stepCounter - 16'd1; // one word done.
        end
    end

    always_ff @(posedge iSystemClock)
    begin
        if (primReady && (primCommand == PrimTimer))
            timerOption <= primOption;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // nand bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge iSystemClock)
    begin
        if (rst)
        begin
            nandWe <= 1'b0;
            nandCle <= 1'b0;
            nandAle <= 1'b0;
        end
        else
        begin
            nandWe <= latchActive || dataActive; // no strobe while the buffer is dry.
            nandCle <= latchActive && !caSelect;
            nandAle <= latchActive && caSelect;
        end
    end

    always_ff @(posedge iSystemClock)
    begin
        nandDq <= latchActive ? caData : bufferData[8*byteLane +: 8]; // lsb first.
    end

endmodule

/* logic/writeDataBuffer.sv */
module writeDataBuffer
    import nandProgramPkg::*;
(
    input  logic        iSystemClock,
    input  logic        rst,
    input  logic        dataValid,
    input  logic [31:0] data,
    input  logic        dataLast,
    input  logic        bufferPop,
    output logic        dataCreditReturn,
    output logic        bufferNotEmpty,
    output logic [31:0] bufferData,
    output logic        bufferLast
);
    logic [31:0]                        wordStore [DataBufferDepth];
    logic                               lastStore [DataBufferDepth];
    logic [$clog2(DataBufferDepth):0]   writePtr; // extra bit tells full from empty.
    logic [$clog2(DataBufferDepth):0]   readPtr;

    assign bufferNotEmpty = (writePtr != readPtr);
    assign bufferData = wordStore[readPtr[$clog2(DataBufferDepth)-1:0]];
    assign bufferLast = lastStore[readPtr[$clog2(DataBufferDepth)-1:0]];

    always_ff @(posedge iSystemClock)
    begin
        if (dataValid)
        begin
            wordStore[writePtr[$clog2(DataBufferDepth)-1:0]] <= data;
            lastStore[writePtr[$clog2(DataBufferDepth)-1:0]] <= dataLast;
        end
    end

    always_ff @(posedge iSystemClock)
    begin
        if (rst)
        begin
            writePtr <= '0;
            readPtr <= '0;
            dataCreditReturn <= 1'b0;
        end
        else
        begin
            if (dataValid)
                writePtr <= writePtr + 1'b1; // host credits keep this from overrunning.
            if (bufferPop && bufferNotEmpty)
                readPtr <= readPtr + 1'b1;
            dataCreditReturn <= bufferPop && bufferNotEmpty;
        end
    end

endmodule
